// File: common/tlb_pkg.sv
package tlb_pkg;

  // entry key widths
  localparam int VPPN_W   = 19;
  localparam int PS_W     = 6;
  localparam int ASID_W   = 10;
  localparam int INV_OP_W = 5;

  // 4MB page, only vppn[18:10] compared
  localparam logic [PS_W-1:0] PS_HUGE = 6'd22;

  localparam int CSR_ADDR_W = 14;
  localparam logic [CSR_ADDR_W-1:0] CSR_TLBIDX  = 14'h10;
  localparam logic [CSR_ADDR_W-1:0] CSR_TLBEHI  = 14'h11;
  localparam logic [CSR_ADDR_W-1:0] CSR_TLBELO0 = 14'h12;
  localparam logic [CSR_ADDR_W-1:0] CSR_TLBELO1 = 14'h13;
  localparam logic [CSR_ADDR_W-1:0] CSR_ASID    = 14'h18;

  localparam int TLBIDX_PS_LO   = 24;
  localparam int TLBIDX_NE      = 31;
  localparam int TLBEHI_VPPN_LO = 13;
  localparam int ELO_V          = 0;
  localparam int ELO_D          = 1;
  localparam int ELO_PLV_LO     = 2;
  localparam int ELO_MAT_LO     = 4;
  localparam int ELO_G          = 6;
  localparam int ELO_PPN_LO     = 8;
  localparam int ELO_PPN_HI     = 27;
  localparam int ASID_BITS_LO   = 16;

  localparam logic [7:0] ASID_BITS_VAL = 8'd10;

  localparam logic [31:0] ELO_WR_MASK =
    ((32'h1 << (ELO_PPN_HI + 1)) - (32'h1 << ELO_PPN_LO)) | (32'h1 << ELO_G) |
    (32'h3 << ELO_MAT_LO) | (32'h3 << ELO_PLV_LO) | (32'h1 << ELO_D) | (32'h1 << ELO_V);
  // per-page bits kept in an entry, G lives in the key
  localparam logic [31:0] ELO_PAGE_MASK = ELO_WR_MASK & ~(32'h1 << ELO_G);
  localparam logic [31:0] TLBEHI_WR_MASK = ((32'h1 << VPPN_W) - 32'h1) << TLBEHI_VPPN_LO;
  localparam logic [31:0] ASID_WR_MASK = (32'h1 << ASID_W) - 32'h1;

  localparam logic [INV_OP_W-1:0] INV_ALL0      = 5'd0;
  localparam logic [INV_OP_W-1:0] INV_ALL1      = 5'd1;
  localparam logic [INV_OP_W-1:0] INV_GLOBAL    = 5'd2;
  localparam logic [INV_OP_W-1:0] INV_NONGLOBAL = 5'd3;
  localparam logic [INV_OP_W-1:0] INV_ASID      = 5'd4;
  localparam logic [INV_OP_W-1:0] INV_ASID_VA   = 5'd5;
  localparam logic [INV_OP_W-1:0] INV_VA        = 5'd6;

endpackage

// File: tlb/tlb_entry_slot.sv
`timescale 1ns/1ps

module tlb_entry_slot (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           we_i,
  input  logic                           w_e_i,
  input  logic [tlb_pkg::VPPN_W-1:0]     w_vppn_i,
  input  logic [tlb_pkg::PS_W-1:0]       w_ps_i,
  input  logic                           w_g_i,
  input  logic [tlb_pkg::ASID_W-1:0]     w_asid_i,
  input  logic [31:0]                    w_lo0_i,
  input  logic [31:0]                    w_lo1_i,
  input  logic                           inv_i,
  input  logic [tlb_pkg::INV_OP_W-1:0]   inv_op_i,
  input  logic [tlb_pkg::ASID_W-1:0]     inv_asid_i,
  input  logic [31:0]                    inv_va_i,
  input  logic [tlb_pkg::VPPN_W-1:0]     srch_vppn_i,
  input  logic [tlb_pkg::ASID_W-1:0]     srch_asid_i,
  output logic                           hit_o,
  output logic                           e_o,
  output logic [tlb_pkg::VPPN_W-1:0]     vppn_o,
  output logic [tlb_pkg::PS_W-1:0]       ps_o,
  output logic                           g_o,
  output logic [tlb_pkg::ASID_W-1:0]     asid_o,
  output logic [31:0]                    lo0_o,
  output logic [31:0]                    lo1_o
);
  import tlb_pkg::*;

  logic              e_q, g_q;
  logic [VPPN_W-1:0] vppn_q;
  logic [PS_W-1:0]   ps_q;
  logic [ASID_W-1:0] asid_q;
  logic [31:0]       lo0_q, lo1_q;
  logic              inv_asid_eq, inv_va_eq, inv_hit;

  // huge pages ignore the low 10 vppn bits
  function automatic logic vppn_match(input logic [VPPN_W-1:0] vppn);
    return (vppn_q[VPPN_W-1:10] == vppn[VPPN_W-1:10]) &&
           ((vppn_q[9:0] == vppn[9:0]) || (ps_q == PS_HUGE));
  endfunction

  assign hit_o = e_q && vppn_match(srch_vppn_i) && ((asid_q == srch_asid_i) || g_q);

  assign inv_asid_eq = (asid_q == inv_asid_i);
  assign inv_va_eq   = vppn_match(inv_va_i[TLBEHI_VPPN_LO +: VPPN_W]);

  always_comb begin
    case (inv_op_i)
      INV_ALL0, INV_ALL1: inv_hit = 1'b1;
      INV_GLOBAL:         inv_hit = g_q;
      INV_NONGLOBAL:      inv_hit = !g_q;
      INV_ASID:           inv_hit = !g_q && inv_asid_eq;
      INV_ASID_VA:        inv_hit = !g_q && inv_asid_eq && inv_va_eq;
      INV_VA:             inv_hit = (g_q || inv_asid_eq) && inv_va_eq;
      default:            inv_hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      e_q <= 1'b0;
    end else if (we_i) begin
      e_q <= w_e_i;
    end else if (inv_i && inv_hit) begin
      e_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (we_i) begin
      vppn_q <= w_vppn_i;
      ps_q   <= w_ps_i;
      g_q    <= w_g_i;
      asid_q <= w_asid_i;
      lo0_q  <= w_lo0_i;
      lo1_q  <= w_lo1_i;
    end
  end

  assign e_o    = e_q;
  assign vppn_o = vppn_q;
  assign ps_o   = ps_q;
  assign g_o    = g_q;
  assign asid_o = asid_q;
  assign lo0_o  = lo0_q;
  assign lo1_o  = lo1_q;

endmodule

// File: tlb/tlb_write_ctrl.sv
`timescale 1ns/1ps

module tlb_write_ctrl #(
  parameter int TLB_ENTRY_NUM = 16
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             tlbwr_i,
  input  logic                             tlbfill_i,
  input  logic                             invtlb_i,
  input  logic [tlb_pkg::INV_OP_W-1:0]     inv_op_i,
  input  logic [31:0]                      tlbidx_i,
  input  logic [31:0]                      tlbehi_i,
  input  logic [31:0]                      tlbelo0_i,
  input  logic [31:0]                      tlbelo1_i,
  input  logic [31:0]                      asid_i,
  output logic [TLB_ENTRY_NUM-1:0]         slot_we_o,
  output logic                             w_e_o,
  output logic [tlb_pkg::VPPN_W-1:0]       w_vppn_o,
  output logic [tlb_pkg::PS_W-1:0]         w_ps_o,
  output logic                             w_g_o,
  output logic [tlb_pkg::ASID_W-1:0]       w_asid_o,
  output logic [31:0]                      w_lo0_o,
  output logic [31:0]                      w_lo1_o
);
  import tlb_pkg::*;

  localparam int IDX_W = $clog2(TLB_ENTRY_NUM);

  // free-running pick for tlbfill
  logic [IDX_W-1:0] fill_cnt_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fill_cnt_q <= '0;
    end else begin
      fill_cnt_q <= fill_cnt_q + 1'b1;
    end
  end

  always_comb begin
    slot_we_o = '0;
    if (tlbwr_i) begin
      slot_we_o[tlbidx_i[IDX_W-1:0]] = 1'b1;
    end
    if (tlbfill_i) begin
      slot_we_o[fill_cnt_q] = 1'b1;
    end
  end

  assign w_e_o    = !tlbidx_i[TLBIDX_NE];
  assign w_vppn_o = tlbehi_i[TLBEHI_VPPN_LO +: VPPN_W];
  assign w_ps_o   = tlbidx_i[TLBIDX_PS_LO +: PS_W];
  assign w_g_o    = tlbelo0_i[ELO_G] && tlbelo1_i[ELO_G];
  assign w_asid_o = asid_i[ASID_W-1:0];
  assign w_lo0_o  = tlbelo0_i & ELO_PAGE_MASK;
  assign w_lo1_o  = tlbelo1_i & ELO_PAGE_MASK;

  a_wr_fill_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(tlbwr_i && tlbfill_i))
    else $error("tlbwr and tlbfill in the same cycle");

  a_inv_op_range: assert property (@(posedge clk) disable iff (!rst_n)
    invtlb_i |-> (inv_op_i <= INV_VA))
    else $error("invtlb op out of range");

endmodule

// File: tlb/tlb_lookup.sv
`timescale 1ns/1ps

module tlb_lookup #(
  parameter int TLB_ENTRY_NUM = 16
) (
  input  logic [TLB_ENTRY_NUM-1:0]                         hit_i,
  input  logic [TLB_ENTRY_NUM-1:0]                         e_i,
  input  logic [TLB_ENTRY_NUM-1:0][tlb_pkg::VPPN_W-1:0]    vppn_i,
  input  logic [TLB_ENTRY_NUM-1:0][tlb_pkg::PS_W-1:0]      ps_i,
  input  logic [TLB_ENTRY_NUM-1:0]                         g_i,
  input  logic [TLB_ENTRY_NUM-1:0][tlb_pkg::ASID_W-1:0]    asid_i,
  input  logic [TLB_ENTRY_NUM-1:0][31:0]                   lo0_i,
  input  logic [TLB_ENTRY_NUM-1:0][31:0]                   lo1_i,
  input  logic [$clog2(TLB_ENTRY_NUM)-1:0]                 rd_idx_i,
  output logic                                             srch_found_o,
  output logic [$clog2(TLB_ENTRY_NUM)-1:0]                 srch_idx_o,
  output logic                                             rd_e_o,
  output logic [tlb_pkg::VPPN_W-1:0]                       rd_vppn_o,
  output logic [tlb_pkg::PS_W-1:0]                         rd_ps_o,
  output logic                                             rd_g_o,
  output logic [tlb_pkg::ASID_W-1:0]                       rd_asid_o,
  output logic [31:0]                                      rd_lo0_o,
  output logic [31:0]                                      rd_lo1_o
);

  localparam int IDX_W = $clog2(TLB_ENTRY_NUM);

  // ascending scan, so the highest hitting slot wins
  always_comb begin
    srch_found_o = 1'b0;
    srch_idx_o   = '0;
    for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
      if (hit_i[i]) begin
        srch_found_o = 1'b1;
        srch_idx_o   = IDX_W'(i);
      end
    end
  end

  assign rd_e_o    = e_i[rd_idx_i];
  assign rd_vppn_o = vppn_i[rd_idx_i];
  assign rd_ps_o   = ps_i[rd_idx_i];
  assign rd_g_o    = g_i[rd_idx_i];
  assign rd_asid_o = asid_i[rd_idx_i];
  assign rd_lo0_o  = lo0_i[rd_idx_i];
  assign rd_lo1_o  = lo1_i[rd_idx_i];

endmodule

// File: hdl/tlb_csr_regs.sv
`timescale 1ns/1ps

module tlb_csr_regs #(
  parameter int TLB_ENTRY_NUM = 16
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   csr_we_i,
  input  logic [tlb_pkg::CSR_ADDR_W-1:0]         csr_w_addr_i,
  input  logic [31:0]                            csr_w_mask_i,
  input  logic [31:0]                            csr_w_data_i,
  input  logic [tlb_pkg::CSR_ADDR_W-1:0]         csr_r_addr_i,
  input  logic                                   tlbsrch_i,
  input  logic                                   tlbrd_i,
  input  logic                                   tlbwr_i,
  input  logic                                   tlbfill_i,
  input  logic                                   invtlb_i,
  input  logic                                   srch_found_i,
  input  logic [$clog2(TLB_ENTRY_NUM)-1:0]       srch_idx_i,
  input  logic                                   rd_e_i,
  input  logic [tlb_pkg::VPPN_W-1:0]             rd_vppn_i,
  input  logic [tlb_pkg::PS_W-1:0]               rd_ps_i,
  input  logic                                   rd_g_i,
  input  logic [tlb_pkg::ASID_W-1:0]             rd_asid_i,
  input  logic [31:0]                            rd_lo0_i,
  input  logic [31:0]                            rd_lo1_i,
  output logic [31:0]                            tlbidx_o,
  output logic [31:0]                            tlbehi_o,
  output logic [31:0]                            tlbelo0_o,
  output logic [31:0]                            tlbelo1_o,
  output logic [31:0]                            asid_o,
  output logic [31:0]                            csr_r_data_o
);
  import tlb_pkg::*;

  localparam int IDX_W = $clog2(TLB_ENTRY_NUM);
  // NE, PS and the implemented index bits
  localparam logic [31:0] TLBIDX_WR_MASK = (32'h1 << TLBIDX_NE) |
    (((32'h1 << PS_W) - 32'h1) << TLBIDX_PS_LO) | 32'(TLB_ENTRY_NUM - 1);

  logic [31:0] tlbidx_q, tlbehi_q, tlbelo0_q, tlbelo1_q, asid_q;

  function automatic logic [31:0] merge(input logic [31:0] old_val,
                                        input logic [31:0] wr_mask);
    logic [31:0] m;
    m = csr_w_mask_i & wr_mask;
    return (old_val & ~m) | (csr_w_data_i & m);
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tlbidx_q  <= '0;
      tlbehi_q  <= '0;
      tlbelo0_q <= '0;
      tlbelo1_q <= '0;
      asid_q    <= '0;
    end else if (csr_we_i) begin
      case (csr_w_addr_i)
        CSR_TLBIDX:  tlbidx_q  <= merge(tlbidx_q, TLBIDX_WR_MASK);
        CSR_TLBEHI:  tlbehi_q  <= merge(tlbehi_q, TLBEHI_WR_MASK);
        CSR_TLBELO0: tlbelo0_q <= merge(tlbelo0_q, ELO_WR_MASK);
        CSR_TLBELO1: tlbelo1_q <= merge(tlbelo1_q, ELO_WR_MASK);
        CSR_ASID:    asid_q    <= merge(asid_q, ASID_WR_MASK);
        default: ;
      endcase
    end else if (tlbsrch_i) begin
      if (srch_found_i) begin
        tlbidx_q[IDX_W-1:0] <= srch_idx_i;
        tlbidx_q[TLBIDX_NE] <= 1'b0;
      end else begin
        tlbidx_q[TLBIDX_NE] <= 1'b1;
      end
    end else if (tlbrd_i) begin
      // invalid entry reads back as all zero with NE set
      tlbidx_q[TLBIDX_PS_LO +: PS_W]     <= rd_e_i ? rd_ps_i : '0;
      tlbidx_q[TLBIDX_NE]                <= !rd_e_i;
      tlbehi_q[TLBEHI_VPPN_LO +: VPPN_W] <= rd_e_i ? rd_vppn_i : '0;
      tlbelo0_q <= rd_e_i ? (rd_lo0_i | (32'(rd_g_i) << ELO_G)) : '0;
      tlbelo1_q <= rd_e_i ? (rd_lo1_i | (32'(rd_g_i) << ELO_G)) : '0;
      asid_q[ASID_W-1:0] <= rd_e_i ? rd_asid_i : '0;
    end
  end

  assign tlbidx_o  = tlbidx_q;
  assign tlbehi_o  = tlbehi_q;
  assign tlbelo0_o = tlbelo0_q;
  assign tlbelo1_o = tlbelo1_q;
  // ASIDBITS is a constant field
  assign asid_o    = asid_q | (32'(ASID_BITS_VAL) << ASID_BITS_LO);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      csr_r_data_o <= '0;
    end else begin
      case (csr_r_addr_i)
        CSR_TLBIDX:  csr_r_data_o <= tlbidx_q;
        CSR_TLBEHI:  csr_r_data_o <= tlbehi_q;
        CSR_TLBELO0: csr_r_data_o <= tlbelo0_q;
        CSR_TLBELO1: csr_r_data_o <= tlbelo1_q;
        CSR_ASID:    csr_r_data_o <= asid_o;
        default:     csr_r_data_o <= '0;
      endcase
    end
  end

  a_one_op: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({csr_we_i, tlbsrch_i, tlbrd_i, tlbwr_i, tlbfill_i, invtlb_i}))
    else $error("more than one csr/tlb strobe in a cycle");

  // slots update at the edge, so lookups need one idle edge after a write
  a_idle_after_write: assert property (@(posedge clk) disable iff (!rst_n)
    (tlbwr_i || tlbfill_i || invtlb_i) |=> !(tlbsrch_i || tlbrd_i))
    else $error("tlbsrch/tlbrd directly after a tlb entry update");

endmodule

// File: hdl/csr_tlb_top.sv
`timescale 1ns/1ps

module csr_tlb_top #(
  parameter int TLB_ENTRY_NUM = 16
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            csr_we_i,
  input  logic [tlb_pkg::CSR_ADDR_W-1:0]  csr_w_addr_i,
  input  logic [31:0]                     csr_w_mask_i,
  input  logic [31:0]                     csr_w_data_i,
  input  logic [tlb_pkg::CSR_ADDR_W-1:0]  csr_r_addr_i,
  input  logic                            tlbsrch_i,
  input  logic                            tlbrd_i,
  input  logic                            tlbwr_i,
  input  logic                            tlbfill_i,
  input  logic                            invtlb_i,
  input  logic [tlb_pkg::INV_OP_W-1:0]    inv_op_i,
  input  logic [tlb_pkg::ASID_W-1:0]      inv_asid_i,
  input  logic [31:0]                     inv_va_i,
  output logic [31:0]                     csr_r_data_o
);
  import tlb_pkg::*;

  localparam int IDX_W = $clog2(TLB_ENTRY_NUM);

  logic [31:0] tlbidx, tlbehi, tlbelo0, tlbelo1, asid;

  logic [TLB_ENTRY_NUM-1:0] slot_we;
  logic                     w_e, w_g;
  logic [VPPN_W-1:0]        w_vppn;
  logic [PS_W-1:0]          w_ps;
  logic [ASID_W-1:0]        w_asid;
  logic [31:0]              w_lo0, w_lo1;

  logic [TLB_ENTRY_NUM-1:0]             slot_hit, slot_e, slot_g;
  logic [TLB_ENTRY_NUM-1:0][VPPN_W-1:0] slot_vppn;
  logic [TLB_ENTRY_NUM-1:0][PS_W-1:0]   slot_ps;
  logic [TLB_ENTRY_NUM-1:0][ASID_W-1:0] slot_asid;
  logic [TLB_ENTRY_NUM-1:0][31:0]       slot_lo0, slot_lo1;

  logic               srch_found;
  logic [IDX_W-1:0]   srch_idx;
  logic               rd_e, rd_g;
  logic [VPPN_W-1:0]  rd_vppn;
  logic [PS_W-1:0]    rd_ps;
  logic [ASID_W-1:0]  rd_asid;
  logic [31:0]        rd_lo0, rd_lo1;

  tlb_csr_regs #(.TLB_ENTRY_NUM(TLB_ENTRY_NUM)) u_csr_regs (
    .clk, .rst_n, .csr_we_i, .csr_w_addr_i, .csr_w_mask_i, .csr_w_data_i, .csr_r_addr_i,
    .tlbsrch_i, .tlbrd_i, .tlbwr_i, .tlbfill_i, .invtlb_i,
    .srch_found_i(srch_found), .srch_idx_i(srch_idx),
    .rd_e_i(rd_e), .rd_vppn_i(rd_vppn), .rd_ps_i(rd_ps), .rd_g_i(rd_g),
    .rd_asid_i(rd_asid), .rd_lo0_i(rd_lo0), .rd_lo1_i(rd_lo1),
    .tlbidx_o(tlbidx), .tlbehi_o(tlbehi), .tlbelo0_o(tlbelo0), .tlbelo1_o(tlbelo1),
    .asid_o(asid), .csr_r_data_o
  );

  tlb_write_ctrl #(.TLB_ENTRY_NUM(TLB_ENTRY_NUM)) u_write_ctrl (
    .clk, .rst_n, .tlbwr_i, .tlbfill_i, .invtlb_i, .inv_op_i,
    .tlbidx_i(tlbidx), .tlbehi_i(tlbehi), .tlbelo0_i(tlbelo0), .tlbelo1_i(tlbelo1),
    .asid_i(asid), .slot_we_o(slot_we), .w_e_o(w_e), .w_vppn_o(w_vppn), .w_ps_o(w_ps),
    .w_g_o(w_g), .w_asid_o(w_asid), .w_lo0_o(w_lo0), .w_lo1_o(w_lo1)
  );

  for (genvar i = 0; i < TLB_ENTRY_NUM; i++) begin : g_slot
    tlb_entry_slot u_slot (
      .clk, .rst_n, .we_i(slot_we[i]), .w_e_i(w_e), .w_vppn_i(w_vppn), .w_ps_i(w_ps),
      .w_g_i(w_g), .w_asid_i(w_asid), .w_lo0_i(w_lo0), .w_lo1_i(w_lo1),
      .inv_i(invtlb_i), .inv_op_i, .inv_asid_i, .inv_va_i,
      .srch_vppn_i(tlbehi[TLBEHI_VPPN_LO +: VPPN_W]), .srch_asid_i(asid[ASID_W-1:0]),
      .hit_o(slot_hit[i]), .e_o(slot_e[i]), .vppn_o(slot_vppn[i]), .ps_o(slot_ps[i]),
      .g_o(slot_g[i]), .asid_o(slot_asid[i]), .lo0_o(slot_lo0[i]), .lo1_o(slot_lo1[i])
    );
  end

  tlb_lookup #(.TLB_ENTRY_NUM(TLB_ENTRY_NUM)) u_lookup (
    .hit_i(slot_hit), .e_i(slot_e), .vppn_i(slot_vppn), .ps_i(slot_ps), .g_i(slot_g),
    .asid_i(slot_asid), .lo0_i(slot_lo0), .lo1_i(slot_lo1), .rd_idx_i(tlbidx[IDX_W-1:0]),
    .srch_found_o(srch_found), .srch_idx_o(srch_idx), .rd_e_o(rd_e), .rd_vppn_o(rd_vppn),
    .rd_ps_o(rd_ps), .rd_g_o(rd_g), .rd_asid_o(rd_asid), .rd_lo0_o(rd_lo0), .rd_lo1_o(rd_lo1)
  );

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release on a rising edge, like any other synchronous input
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: tb/csr_tlb_tb.sv
`timescale 1ns/1ps

module csr_tlb_tb;
  import tlb_pkg::*;

  localparam int TLB_N = 16;
  localparam logic [31:0] SEED = 32'he46b_00be;
  localparam int RESET_TIMEOUT = 100;

  // writable bits of each register
  localparam logic [31:0] IDX_BITS   = 32'hBF00_0000 | 32'(TLB_N - 1);
  localparam logic [31:0] EHI_BITS   = 32'hFFFF_E000;
  localparam logic [31:0] ELO_BITS   = 32'h0FFF_FF7F;
  localparam logic [31:0] PAGE_BITS  = 32'h0FFF_FF3F;
  localparam logic [31:0] ASID_FIELD = 32'h0000_03FF;
  localparam logic [31:0] ASID_CONST = 32'h000A_0000;
  localparam logic [PS_W-1:0] PS_4K  = 6'd12;
  localparam logic [PS_W-1:0] PS_4M  = 6'd22;

  // {invtlb, tlbfill, tlbwr, tlbrd, tlbsrch}
  localparam logic [4:0] OP_SRCH = 5'b00001;
  localparam logic [4:0] OP_RD   = 5'b00010;
  localparam logic [4:0] OP_WR   = 5'b00100;
  localparam logic [4:0] OP_FILL = 5'b01000;

  logic                  clk, rst_n;
  logic                  csr_we_i;
  logic [CSR_ADDR_W-1:0] csr_w_addr_i, csr_r_addr_i;
  logic [31:0]           csr_w_mask_i, csr_w_data_i;
  logic                  tlbsrch_i, tlbrd_i, tlbwr_i, tlbfill_i, invtlb_i;
  logic [INV_OP_W-1:0]   inv_op_i;
  logic [ASID_W-1:0]     inv_asid_i;
  logic [31:0]           inv_va_i;
  logic [31:0]           csr_r_data_o;

  // reference copy of the TLB contents
  logic              m_valid [TLB_N];
  logic [VPPN_W-1:0] m_vppn  [TLB_N];
  logic [PS_W-1:0]   m_ps    [TLB_N];
  logic              m_g     [TLB_N];
  logic [ASID_W-1:0] m_asid  [TLB_N];
  logic [31:0]       m_lo0   [TLB_N];
  logic [31:0]       m_lo1   [TLB_N];

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(16)) u_clock_gen (
    .clk_o(clk),
    .rst_n_o(rst_n)
  );

  csr_tlb_top #(.TLB_ENTRY_NUM(TLB_N)) u_csr_tlb_top (
    .clk, .rst_n, .csr_we_i, .csr_w_addr_i, .csr_w_mask_i, .csr_w_data_i, .csr_r_addr_i,
    .tlbsrch_i, .tlbrd_i, .tlbwr_i, .tlbfill_i, .invtlb_i, .inv_op_i, .inv_asid_i,
    .inv_va_i, .csr_r_data_o
  );

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_csr(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      cycles++;
      if (cycles > RESET_TIMEOUT) begin
        $display("timeout: reset was still asserted after %0d cycles", RESET_TIMEOUT);
        abort_run();
      end
    end
  endtask

  task automatic csr_write(input logic [CSR_ADDR_W-1:0] addr, input logic [31:0] mask,
                           input logic [31:0] data);
    @(posedge clk);
    csr_we_i     <= 1'b1;
    csr_w_addr_i <= addr;
    csr_w_mask_i <= mask;
    csr_w_data_i <= data;
    @(posedge clk);
    csr_we_i <= 1'b0;
  endtask

  task automatic set_csr(input logic [CSR_ADDR_W-1:0] addr, input logic [31:0] data);
    csr_write(addr, 32'hFFFF_FFFF, data);
  endtask

  // data comes back one cycle after the address
  task automatic csr_read(input logic [CSR_ADDR_W-1:0] addr, output logic [31:0] data);
    @(posedge clk);
    csr_r_addr_i <= addr;
    @(posedge clk);
    @(negedge clk);
    data = csr_r_data_o;
  endtask

  task automatic pulse_op(input logic [4:0] strobes);
    @(posedge clk);
    {invtlb_i, tlbfill_i, tlbwr_i, tlbrd_i, tlbsrch_i} <= strobes;
    @(posedge clk);
    {invtlb_i, tlbfill_i, tlbwr_i, tlbrd_i, tlbsrch_i} <= 5'b0;
  endtask

  function automatic logic [31:0] writable_mask(input logic [CSR_ADDR_W-1:0] addr);
    case (addr)
      CSR_TLBIDX:  return IDX_BITS;
      CSR_TLBEHI:  return EHI_BITS;
      CSR_TLBELO0: return ELO_BITS;
      CSR_TLBELO1: return ELO_BITS;
      CSR_ASID:    return ASID_FIELD;
      default:     return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] rand_elo(input logic g);
    return ($urandom() & PAGE_BITS) | (32'(g) << 6);
  endfunction

  function automatic logic model_vppn_match(input int i, input logic [VPPN_W-1:0] vppn);
    if (m_vppn[i][18:10] != vppn[18:10]) begin
      return 1'b0;
    end
    return (m_ps[i] == PS_4M) || (m_vppn[i][9:0] == vppn[9:0]);
  endfunction

  // TLBIDX after a search that started from zero
  function automatic logic [31:0] expected_srch(input logic [VPPN_W-1:0] vppn,
                                                input logic [ASID_W-1:0] asid);
    logic [31:0] res;
    res = 32'h8000_0000;
    for (int i = 0; i < TLB_N; i++) begin
      if (m_valid[i] && model_vppn_match(i, vppn) && (m_g[i] || m_asid[i] == asid)) begin
        res = 32'(i);
      end
    end
    return res;
  endfunction

  task automatic model_store(input int idx, input logic [VPPN_W-1:0] vppn,
                             input logic [PS_W-1:0] ps, input logic [ASID_W-1:0] asid,
                             input logic [31:0] lo0, input logic [31:0] lo1);
    m_valid[idx] = 1'b1;
    m_vppn[idx]  = vppn;
    m_ps[idx]    = ps;
    m_asid[idx]  = asid;
    m_g[idx]     = lo0[6] & lo1[6];
    m_lo0[idx]   = lo0 & PAGE_BITS;
    m_lo1[idx]   = lo1 & PAGE_BITS;
  endtask

  task automatic model_invalidate(input int op, input logic [ASID_W-1:0] asid,
                                  input logic [VPPN_W-1:0] vppn);
    logic asid_eq, va_eq, kill;
    for (int i = 0; i < TLB_N; i++) begin
      asid_eq = (m_asid[i] == asid);
      va_eq   = model_vppn_match(i, vppn);
      case (op)
        0, 1:    kill = 1'b1;
        2:       kill = m_g[i];
        3:       kill = !m_g[i];
        4:       kill = !m_g[i] && asid_eq;
        5:       kill = !m_g[i] && asid_eq && va_eq;
        6:       kill = (m_g[i] || asid_eq) && va_eq;
        default: kill = 1'b0;
      endcase
      if (kill) begin
        m_valid[i] = 1'b0;
      end
    end
  endtask

  task automatic do_invtlb(input int op, input logic [ASID_W-1:0] asid, input logic [31:0] va);
    @(posedge clk);
    inv_op_i   <= INV_OP_W'(op);
    inv_asid_i <= asid;
    inv_va_i   <= va;
    invtlb_i   <= 1'b1;
    @(posedge clk);
    invtlb_i <= 1'b0;
    model_invalidate(op, asid, va[31:13]);
  endtask

  task automatic write_entry(input int idx, input logic [VPPN_W-1:0] vppn,
                             input logic [PS_W-1:0] ps, input logic [ASID_W-1:0] asid,
                             input logic [31:0] lo0, input logic [31:0] lo1);
    set_csr(CSR_TLBIDX, (32'(ps) << 24) | 32'(idx));
    set_csr(CSR_TLBEHI, 32'(vppn) << 13);
    set_csr(CSR_TLBELO0, lo0);
    set_csr(CSR_TLBELO1, lo1);
    set_csr(CSR_ASID, 32'(asid));
    pulse_op(OP_WR);
    model_store(idx, vppn, ps, asid, lo0, lo1);
  endtask

  task automatic check_search(input logic [VPPN_W-1:0] vppn, input logic [ASID_W-1:0] asid,
                              input string what);
    logic [31:0] got;
    set_csr(CSR_TLBIDX, 32'h0);
    set_csr(CSR_TLBEHI, 32'(vppn) << 13);
    set_csr(CSR_ASID, 32'(asid));
    pulse_op(OP_SRCH);
    csr_read(CSR_TLBIDX, got);
    check_csr(what, got, expected_srch(vppn, asid));
  endtask

  // clobber the CSRs first so every field must come from the entry
  task automatic check_tlbrd(input int idx);
    logic [31:0] got, e_idx, e_ehi, e_lo0, e_lo1, e_asid;
    set_csr(CSR_TLBIDX, 32'(idx));
    set_csr(CSR_TLBEHI, $urandom());
    set_csr(CSR_TLBELO0, $urandom());
    set_csr(CSR_TLBELO1, $urandom());
    set_csr(CSR_ASID, $urandom());
    pulse_op(OP_RD);
    if (m_valid[idx]) begin
      e_idx  = (32'(m_ps[idx]) << 24) | 32'(idx);
      e_ehi  = 32'(m_vppn[idx]) << 13;
      e_lo0  = m_lo0[idx] | (32'(m_g[idx]) << 6);
      e_lo1  = m_lo1[idx] | (32'(m_g[idx]) << 6);
      e_asid = 32'(m_asid[idx]) | ASID_CONST;
    end else begin
      e_idx  = 32'h8000_0000 | 32'(idx);
      e_ehi  = 32'h0;
      e_lo0  = 32'h0;
      e_lo1  = 32'h0;
      e_asid = ASID_CONST;
    end
    csr_read(CSR_TLBIDX, got);
    check_csr("tlbrd tlbidx", got, e_idx);
    csr_read(CSR_TLBEHI, got);
    check_csr("tlbrd tlbehi", got, e_ehi);
    csr_read(CSR_TLBELO0, got);
    check_csr("tlbrd tlbelo0", got, e_lo0);
    csr_read(CSR_TLBELO1, got);
    check_csr("tlbrd tlbelo1", got, e_lo1);
    csr_read(CSR_ASID, got);
    check_csr("tlbrd asid", got, e_asid);
  endtask

  task automatic clear_tlb();
    do_invtlb(0, '0, 32'h0);
  endtask

  task automatic test_reset_values();
    logic [31:0] got;
    csr_read(CSR_TLBIDX, got);
    check_csr("reset tlbidx", got, 32'h0);
    csr_read(CSR_TLBEHI, got);
    check_csr("reset tlbehi", got, 32'h0);
    csr_read(CSR_TLBELO0, got);
    check_csr("reset tlbelo0", got, 32'h0);
    csr_read(CSR_TLBELO1, got);
    check_csr("reset tlbelo1", got, 32'h0);
    csr_read(CSR_ASID, got);
    check_csr("reset asid", got, ASID_CONST);
    csr_read(14'h20, got);
    check_csr("reset unmapped", got, 32'h0);
  endtask

  task automatic masked_write_check(input logic [CSR_ADDR_W-1:0] addr, input string what,
                                    input logic [31:0] old_val, output logic [31:0] new_val);
    logic [31:0] mask, data, m, got;
    mask = $urandom();
    data = $urandom();
    m = mask & writable_mask(addr);
    new_val = (old_val & ~m) | (data & m);
    csr_write(addr, mask, data);
    csr_read(addr, got);
    check_csr(what, got, new_val);
  endtask

  task automatic test_masked_write();
    logic [31:0] got, idx_v, ehi_v, lo0_v, lo1_v, asid_v;
    // contents as left by reset
    idx_v  = 32'h0;
    ehi_v  = 32'h0;
    lo0_v  = 32'h0;
    lo1_v  = 32'h0;
    asid_v = ASID_CONST;
    repeat (3) begin
      masked_write_check(CSR_TLBIDX, "masked tlbidx", idx_v, idx_v);
      masked_write_check(CSR_TLBEHI, "masked tlbehi", ehi_v, ehi_v);
      masked_write_check(CSR_TLBELO0, "masked tlbelo0", lo0_v, lo0_v);
      masked_write_check(CSR_TLBELO1, "masked tlbelo1", lo1_v, lo1_v);
      masked_write_check(CSR_ASID, "masked asid", asid_v, asid_v);
    end
    csr_write(14'h20, 32'hFFFF_FFFF, $urandom());
    csr_read(14'h20, got);
    check_csr("unmapped write", got, 32'h0);
  endtask

  task automatic test_write_search_read();
    logic [VPPN_W-1:0] vppn;
    logic [ASID_W-1:0] asid;
    vppn = VPPN_W'($urandom());
    asid = ASID_W'($urandom());
    // nothing written since reset, so the search must miss
    check_search(vppn, asid, "tlbsrch on empty tlb");
    clear_tlb();
    // G set in one page only, so the entry is not global
    write_entry(5, vppn, PS_4K, asid, rand_elo(1'b1), rand_elo(1'b0));
    check_search(vppn, asid, "tlbsrch own asid");
    check_search(vppn, asid ^ 10'h001, "tlbsrch other asid");
    check_tlbrd(5);
    check_tlbrd(3);
  endtask

  task automatic test_huge_page();
    logic [VPPN_W-1:0] vppn, vppn_s;
    logic [ASID_W-1:0] asid;
    clear_tlb();
    vppn   = VPPN_W'($urandom());
    vppn_s = VPPN_W'($urandom());
    asid   = ASID_W'($urandom());
    write_entry(7, vppn, PS_4M, asid, rand_elo(1'b0), rand_elo(1'b0));
    write_entry(2, vppn_s, PS_4K, asid, rand_elo(1'b0), rand_elo(1'b0));
    check_search(vppn ^ {9'h0, 10'($urandom()) | 10'h001}, asid, "ps 22 low bits differ");
    check_search(vppn ^ 19'h00400, asid, "ps 22 upper bit differs");
    check_search(vppn_s ^ 19'h00001, asid, "ps 12 low bit differs");
  endtask

  task automatic test_invtlb();
    logic [VPPN_W-1:0] va_vppn, other_vppn;
    logic [ASID_W-1:0] asid_a, asid_b, asid_c;
    va_vppn    = VPPN_W'($urandom());
    other_vppn = va_vppn ^ 19'h40000;
    asid_a     = ASID_W'($urandom());
    asid_b     = asid_a ^ 10'h155;
    asid_c     = asid_a ^ 10'h2AA;
    for (int op = 0; op <= 6; op++) begin
      clear_tlb();
      write_entry(0, va_vppn, PS_4K, asid_a, rand_elo(1'b1), rand_elo(1'b1));
      write_entry(1, va_vppn, PS_4K, asid_a, rand_elo(1'b0), rand_elo(1'b1));
      write_entry(2, va_vppn, PS_4K, asid_b, rand_elo(1'b1), rand_elo(1'b0));
      write_entry(3, other_vppn, PS_4K, asid_a, rand_elo(1'b0), rand_elo(1'b0));
      do_invtlb(op, asid_a, 32'(va_vppn) << 13);
      check_search(va_vppn, asid_a, $sformatf("invtlb op %0d, va with asid a", op));
      check_search(va_vppn, asid_b, $sformatf("invtlb op %0d, va with asid b", op));
      check_search(va_vppn, asid_c, $sformatf("invtlb op %0d, va with asid c", op));
      check_search(other_vppn, asid_a, $sformatf("invtlb op %0d, other va", op));
    end
  endtask

  task automatic test_tlbfill();
    logic [VPPN_W-1:0] vppn;
    logic [ASID_W-1:0] asid;
    logic [31:0] lo0, lo1, got;
    clear_tlb();
    vppn = VPPN_W'($urandom());
    asid = ASID_W'($urandom());
    lo0  = rand_elo(1'b1);
    lo1  = rand_elo(1'b1);
    set_csr(CSR_TLBIDX, 32'(PS_4K) << 24);
    set_csr(CSR_TLBEHI, 32'(vppn) << 13);
    set_csr(CSR_TLBELO0, lo0);
    set_csr(CSR_TLBELO1, lo1);
    set_csr(CSR_ASID, 32'(asid));
    pulse_op(OP_FILL);
    pulse_op(OP_SRCH);
    csr_read(CSR_TLBIDX, got);
    // fill index not known in advance
    check_csr("tlbfill search ne and ps", got & 32'hBF00_0000, 32'(PS_4K) << 24);
    model_store(int'(got[3:0]), vppn, PS_4K, asid, lo0, lo1);
    check_tlbrd(int'(got[3:0]));
  endtask

  initial begin
    csr_we_i     = 1'b0;
    csr_w_addr_i = '0;
    csr_w_mask_i = '0;
    csr_w_data_i = '0;
    csr_r_addr_i = '0;
    tlbsrch_i    = 1'b0;
    tlbrd_i      = 1'b0;
    tlbwr_i      = 1'b0;
    tlbfill_i    = 1'b0;
    invtlb_i     = 1'b0;
    inv_op_i     = '0;
    inv_asid_i   = '0;
    inv_va_i     = '0;
    for (int i = 0; i < TLB_N; i++) begin
      m_valid[i] = 1'b0;
    end
    void'($urandom(SEED));
    wait_reset_release();
    test_reset_values();
    test_masked_write();
    test_write_search_read();
    test_huge_page();
    test_invtlb();
    test_tlbfill();
    $display("TEST OK");
    $finish;
  end

endmodule

// File: files.f
common/tlb_pkg.sv
tlb/tlb_entry_slot.sv
tlb/tlb_write_ctrl.sv
tlb/tlb_lookup.sv
hdl/tlb_csr_regs.sv
hdl/csr_tlb_top.sv
tb/tb_clock_gen.sv
tb/csr_tlb_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= csr_tlb_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
